//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the RV32I core testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
  -f vlog.f --top-module tb_rv32i_cpu -Mdir obj_dir \
  && ./obj_dir/Vtb_rv32i_cpu +verilator+error+limit+100 > sim.log 2>&1

cat sim.log 2>/dev/null
grep -qx "PASS: all tests" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

//--- rv32i_alu.sv
// Integer ALU with flags
`timescale 1ns/10ps
`include "rv32i_consts.svh"

module rv32i_alu (
  input  logic [`RV_XLEN-1:0] a,
  input  logic [`RV_XLEN-1:0] b,
  input  rv32i_pkg::alu_op_e  alu_op,
  output logic [`RV_XLEN-1:0] result,
  output logic                n,       // Negative
  output logic                z,       // Zero
  output logic                c,       // Carry out, no borrow on sub
  output logic                v        // Signed overflow
);
  import rv32i_pkg::*;

  logic                is_sub;
  logic                is_arith;   // Add or sub, the only ops with c and v
  logic [`RV_XLEN-1:0] b_eff;      // b inverted for sub
  logic [`RV_XLEN:0]   sum;        // Carry in the top bit

  assign is_sub   = (alu_op == ALU_SUB);
  assign is_arith = is_sub || (alu_op == ALU_ADD);
  assign b_eff    = is_sub ? ~b : b;
  assign sum      = {1'b0, a} + {1'b0, b_eff} + {{`RV_XLEN{1'b0}}, is_sub};

  always_comb
  begin
    case (alu_op)
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_XOR: result = a ^ b;
      ALU_SLL: result = a << b[4:0];
      default: result = sum[`RV_XLEN-1:0];  // add and sub
    endcase
  end

  assign n = result[`RV_XLEN-1];
  assign z = (result == '0);
  assign c = is_arith & sum[`RV_XLEN];
  // Same operand signs and a result of the other sign
  assign v = is_arith & (a[`RV_XLEN-1] == b_eff[`RV_XLEN-1]) &
             (sum[`RV_XLEN-1] != a[`RV_XLEN-1]);

endmodule

//--- rv32i_checker.sv
// Core port assertions
`timescale 1ns/10ps
`include "rv32i_consts.svh"

module rv32i_checker (
  input logic                clk,
  input logic                reset,
  input logic [`RV_XLEN-1:0] pc,
  input logic                mem_write
);

  int fail_count = 0;  // Failed assertions so far

  // Fetch only on word boundaries
  pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else
    begin
      fail_count++;
      $error("pc %h is not word aligned", pc);
    end

  // Store strobe always a clean level once running
  write_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(mem_write))
    else
    begin
      fail_count++;
      $error("mem_write is unknown");
    end

  // No store while the pipeline is held in reset
  write_in_reset: assert property (@(posedge clk) reset |-> !mem_write)
    else
    begin
      fail_count++;
      $error("mem_write high during reset");
    end

endmodule

bind rv32i_cpu rv32i_checker u_checker (
  .clk       (clk),
  .reset     (reset),
  .pc        (pc),
  .mem_write (mem_write)
);

//--- rv32i_consts.svh
// RV32I core constants
`ifndef RV32I_CONSTS_SVH
`define RV32I_CONSTS_SVH

// Datapath and address width
`define RV_XLEN 32

// Register index width
`define RV_REG_ADDR_W 5

// Architectural registers including x0
`define RV_NUM_REGS 32

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// addi x0, x0, 0 used to squash IF/ID
`define RV_NOP_INST 32'h0000_0013

`endif

//--- rv32i_cpu.sv
// Five-stage RV32I core
`timescale 1ns/10ps
`include "rv32i_consts.svh"

module rv32i_cpu (
  input  logic                clk,
  input  logic                reset,
  input  logic [`RV_XLEN-1:0] inst,       // Combinational from instruction memory
  output logic [`RV_XLEN-1:0] pc,
  input  logic [`RV_XLEN-1:0] mem_rdata,  // Combinational from mem_addr
  output logic [`RV_XLEN-1:0] mem_addr,
  output logic [`RV_XLEN-1:0] mem_wdata,
  output logic                mem_write
);
  import rv32i_pkg::*;

  logic [`RV_XLEN-1:0]       id_inst, id_pc, imm, rs1_data, rs2_data;
  logic [`RV_REG_ADDR_W-1:0] id_rs1, id_rs2, id_rd;
  logic [2:0]                id_funct3;
  logic                      regwrite, alusrc, memread, memwrite, memtoreg;
  logic                      branch, jal, jalr, lui;
  alu_op_e                   alu_op;
  logic                      stall, redirect;
  logic [`RV_XLEN-1:0]       redirect_pc;
  fwd_sel_e                  fwd_a, fwd_b;
  logic [`RV_REG_ADDR_W-1:0] ex_rs1, ex_rs2, ex_rd, mem_rd, wb_rd;
  logic                      ex_memread, mem_regwrite, mem_memread, mem_memtoreg;
  logic                      wb_we;
  logic [`RV_XLEN-1:0]       wb_data;

  // Register fields of the decode instruction
  assign id_rs1    = id_inst[19:15];
  assign id_rs2    = id_inst[24:20];
  assign id_rd     = id_inst[11:7];
  assign id_funct3 = id_inst[14:12];

  rv32i_fetch u_fetch (
    .clk(clk), .reset(reset), .inst(inst), .stall(stall),
    .redirect(redirect), .redirect_pc(redirect_pc),
    .pc(pc), .id_inst(id_inst), .id_pc(id_pc)
  );

  rv32i_decoder u_decoder (
    .id_inst(id_inst), .regwrite(regwrite), .alusrc(alusrc), .memread(memread),
    .memwrite(memwrite), .memtoreg(memtoreg), .branch(branch), .jal(jal),
    .jalr(jalr), .lui(lui), .alu_op(alu_op), .imm(imm)
  );

  // Written from writeback
  rv32i_regfile u_regfile (
    .clk(clk), .reset(reset), .rs1(id_rs1), .rs2(id_rs2), .rd(wb_rd),
    .we(wb_we), .rd_data(wb_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  rv32i_hazard_unit u_hazard (
    .id_rs1(id_rs1), .id_rs2(id_rs2), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2),
    .ex_rd(ex_rd), .ex_memread(ex_memread), .mem_rd(mem_rd),
    .mem_regwrite(mem_regwrite), .mem_memread(mem_memread), .wb_rd(wb_rd),
    .wb_we(wb_we), .stall(stall), .fwd_a(fwd_a), .fwd_b(fwd_b)
  );

  // EX/MEM result drives the data address directly
  rv32i_execute u_execute (
    .clk(clk), .reset(reset), .stall(stall), .regwrite(regwrite),
    .alusrc(alusrc), .memread(memread), .memwrite(memwrite), .memtoreg(memtoreg),
    .branch(branch), .jal(jal), .jalr(jalr), .lui(lui), .alu_op(alu_op),
    .imm(imm), .id_funct3(id_funct3), .id_pc(id_pc), .id_rs1(id_rs1),
    .id_rs2(id_rs2), .id_rd(id_rd), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .fwd_a(fwd_a), .fwd_b(fwd_b), .wb_data(wb_data), .ex_rs1(ex_rs1),
    .ex_rs2(ex_rs2), .ex_rd(ex_rd), .ex_memread(ex_memread),
    .redirect(redirect), .redirect_pc(redirect_pc), .mem_result(mem_addr),
    .mem_wdata(mem_wdata), .mem_rd(mem_rd), .mem_regwrite(mem_regwrite),
    .mem_memread(mem_memread), .mem_memtoreg(mem_memtoreg), .mem_write(mem_write)
  );

  rv32i_writeback u_writeback (
    .clk(clk), .reset(reset), .mem_result(mem_addr), .mem_rdata(mem_rdata),
    .mem_rd(mem_rd), .mem_regwrite(mem_regwrite), .mem_memtoreg(mem_memtoreg),
    .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data)
  );

endmodule

//--- rv32i_decoder.sv
// Decode stage control
`timescale 1ns/10ps
`include "rv32i_consts.svh"

module rv32i_decoder (
  input  logic [`RV_XLEN-1:0] id_inst,   // Instruction held in IF/ID
  output logic                regwrite,
  output logic                alusrc,    // Immediate as ALU operand b
  output logic                memread,
  output logic                memwrite,
  output logic                memtoreg,
  output logic                branch,
  output logic                jal,
  output logic                jalr,
  output logic                lui,
  output rv32i_pkg::alu_op_e  alu_op,
  output logic [`RV_XLEN-1:0] imm        // Sign-extended immediate
);
  import rv32i_pkg::*;

  opcode_e             opcode;
  logic [2:0]          funct3;
  logic                funct7_5;        // Picks sub over add
  logic [`RV_XLEN-1:0] imm_i, imm_s, imm_b, imm_j, imm_u;

  assign opcode   = opcode_e'(id_inst[6:0]);
  assign funct3   = id_inst[14:12];
  assign funct7_5 = id_inst[30];

  // Immediate formats
  assign imm_i = {{(`RV_XLEN-12){id_inst[31]}}, id_inst[31:20]};
  assign imm_s = {{(`RV_XLEN-12){id_inst[31]}}, id_inst[31:25], id_inst[11:7]};
  assign imm_b = {{(`RV_XLEN-13){id_inst[31]}}, id_inst[31], id_inst[7],
                  id_inst[30:25], id_inst[11:8], 1'b0};
  assign imm_j = {{(`RV_XLEN-21){id_inst[31]}}, id_inst[31], id_inst[19:12],
                  id_inst[20], id_inst[30:21], 1'b0};
  assign imm_u = {id_inst[31:12], 12'b0};

  always_comb
  begin
    // Everything off unless the opcode says otherwise
    regwrite = 1'b0;
    alusrc   = 1'b0;
    memread  = 1'b0;
    memwrite = 1'b0;
    memtoreg = 1'b0;
    branch   = 1'b0;
    jal      = 1'b0;
    jalr     = 1'b0;
    lui      = 1'b0;
    alu_op   = ALU_ADD;
    imm      = '0;
    case (opcode)
      OP_R:
      begin
        regwrite = 1'b1;
        case ({funct7_5, funct3})
          4'b1_000: alu_op = ALU_SUB;
          4'b0_111: alu_op = ALU_AND;
          4'b0_110: alu_op = ALU_OR;
          default:  alu_op = ALU_ADD;
        endcase
      end
      OP_I_ARITH:
      begin
        regwrite = 1'b1;
        alusrc   = 1'b1;
        imm      = imm_i;
        case (funct3)
          3'b001:  alu_op = ALU_SLL;  // slli, shamt in imm[4:0]
          3'b100:  alu_op = ALU_XOR;
          3'b110:  alu_op = ALU_OR;
          3'b111:  alu_op = ALU_AND;
          default: alu_op = ALU_ADD;  // addi
        endcase
      end
      OP_LOAD:
      begin
        regwrite = 1'b1;
        alusrc   = 1'b1;
        memread  = 1'b1;
        memtoreg = 1'b1;
        imm      = imm_i;
      end
      OP_STORE:
      begin
        alusrc   = 1'b1;  // Address is rs1 + imm
        memwrite = 1'b1;
        imm      = imm_s;
      end
      OP_BRANCH:
      begin
        branch = 1'b1;
        alu_op = ALU_SUB;  // Flags from rs1 - rs2
        imm    = imm_b;
      end
      OP_JAL:
      begin
        regwrite = 1'b1;
        jal      = 1'b1;
        imm      = imm_j;
      end
      OP_JALR:
      begin
        regwrite = 1'b1;
        alusrc   = 1'b1;  // Target rs1 + imm
        jalr     = 1'b1;
        imm      = imm_i;
      end
      OP_LUI:
      begin
        regwrite = 1'b1;
        alusrc   = 1'b1;
        lui      = 1'b1;
        imm      = imm_u;
      end
      default: ;
    endcase
  end

endmodule

//--- rv32i_execute.sv
// Execute stage with ID/EX and EX/MEM
`timescale 1ns/10ps
`include "rv32i_consts.svh"

module rv32i_execute (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      stall,       // Load-use bubble
  input  logic                      regwrite,
  input  logic                      alusrc,
  input  logic                      memread,
  input  logic                      memwrite,
  input  logic                      memtoreg,
  input  logic                      branch,
  input  logic                      jal,
  input  logic                      jalr,
  input  logic                      lui,
  input  rv32i_pkg::alu_op_e        alu_op,
  input  logic [`RV_XLEN-1:0]       imm,
  input  logic [2:0]                id_funct3,   // Branch condition
  input  logic [`RV_XLEN-1:0]       id_pc,
  input  logic [`RV_REG_ADDR_W-1:0] id_rs1,
  input  logic [`RV_REG_ADDR_W-1:0] id_rs2,
  input  logic [`RV_REG_ADDR_W-1:0] id_rd,
  input  logic [`RV_XLEN-1:0]       rs1_data,
  input  logic [`RV_XLEN-1:0]       rs2_data,
  input  rv32i_pkg::fwd_sel_e       fwd_a,
  input  rv32i_pkg::fwd_sel_e       fwd_b,
  input  logic [`RV_XLEN-1:0]       wb_data,
  output logic [`RV_REG_ADDR_W-1:0] ex_rs1,
  output logic [`RV_REG_ADDR_W-1:0] ex_rs2,
  output logic [`RV_REG_ADDR_W-1:0] ex_rd,
  output logic                      ex_memread,
  output logic                      redirect,
  output logic [`RV_XLEN-1:0]       redirect_pc,
  output logic [`RV_XLEN-1:0]       mem_result,  // Also the data address
  output logic [`RV_XLEN-1:0]       mem_wdata,
  output logic [`RV_REG_ADDR_W-1:0] mem_rd,
  output logic                      mem_regwrite,
  output logic                      mem_memread,
  output logic                      mem_memtoreg,
  output logic                      mem_write
);
  import rv32i_pkg::*;

  logic                ex_regwrite, ex_alusrc, ex_memwrite, ex_memtoreg;
  logic                ex_branch, ex_jal, ex_jalr, ex_lui;
  alu_op_e             ex_alu_op;
  logic [`RV_XLEN-1:0] ex_pc, ex_imm, ex_rs1_data, ex_rs2_data;
  logic [2:0]          ex_funct3;
  logic                bubble;
  logic [`RV_XLEN-1:0] op_a, op_b;            // Forwarded register values
  logic [`RV_XLEN-1:0] alu_a, alu_b, alu_y;
  logic [`RV_XLEN-1:0] link_pc;
  logic                n, z, c, v;
  logic                taken;

  function automatic logic [`RV_XLEN-1:0] fwd_mux(
    input fwd_sel_e            sel,
    input logic [`RV_XLEN-1:0] rf_val,
    input logic [`RV_XLEN-1:0] mem_val,
    input logic [`RV_XLEN-1:0] wb_val
  );
    case (sel)
      FWD_MEM: return mem_val;
      FWD_WB:  return wb_val;
      default: return rf_val;
    endcase
  endfunction

  // Squash the decode instruction on stall or on our own redirect
  assign bubble = stall | redirect;

  // ID/EX controls
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      ex_regwrite <= 1'b0;
      ex_alusrc   <= 1'b0;
      ex_memread  <= 1'b0;
      ex_memwrite <= 1'b0;
      ex_memtoreg <= 1'b0;
      ex_branch   <= 1'b0;
      ex_jal      <= 1'b0;
      ex_jalr     <= 1'b0;
      ex_lui      <= 1'b0;
      ex_alu_op   <= ALU_ADD;
    end
    else
    begin
      ex_regwrite <= regwrite & ~bubble;
      ex_alusrc   <= alusrc & ~bubble;
      ex_memread  <= memread & ~bubble;
      ex_memwrite <= memwrite & ~bubble;
      ex_memtoreg <= memtoreg & ~bubble;
      ex_branch   <= branch & ~bubble;
      ex_jal      <= jal & ~bubble;
      ex_jalr     <= jalr & ~bubble;
      ex_lui      <= lui & ~bubble;
      ex_alu_op   <= bubble ? ALU_ADD : alu_op;
    end
  end

  // ID/EX payload, harmless under a bubble
  always_ff @(posedge clk)
  begin
    ex_pc       <= id_pc;
    ex_imm      <= imm;
    ex_funct3   <= id_funct3;
    ex_rs1      <= id_rs1;
    ex_rs2      <= id_rs2;
    ex_rd       <= id_rd;
    ex_rs1_data <= rs1_data;
    ex_rs2_data <= rs2_data;
  end

  assign op_a  = fwd_mux(fwd_a, ex_rs1_data, mem_result, wb_data);
  assign op_b  = fwd_mux(fwd_b, ex_rs2_data, mem_result, wb_data);
  assign alu_a = ex_lui ? '0 : op_a;      // lui is 0 + imm
  assign alu_b = ex_alusrc ? ex_imm : op_b;

  rv32i_alu u_alu (
    .a      (alu_a),
    .b      (alu_b),
    .alu_op (ex_alu_op),
    .result (alu_y),
    .n      (n),
    .z      (z),
    .c      (c),
    .v      (v)
  );

  assign link_pc = ex_pc + `RV_XLEN'd4;

  // Conditions on rs1 - rs2
  always_comb
  begin
    case (ex_funct3)
      3'b000:  taken = z;         // beq
      3'b001:  taken = ~z;        // bne
      3'b100:  taken = n ^ v;     // blt
      3'b101:  taken = ~(n ^ v);  // bge
      3'b110:  taken = ~c;        // bltu
      3'b111:  taken = c;         // bgeu
      default: taken = 1'b0;
    endcase
  end

  assign redirect    = (ex_branch & taken) | ex_jal | ex_jalr;
  assign redirect_pc = ex_jalr ? {alu_y[`RV_XLEN-1:1], 1'b0} : ex_pc + ex_imm;

  // EX/MEM controls
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      mem_regwrite <= 1'b0;
      mem_memread  <= 1'b0;
      mem_memtoreg <= 1'b0;
      mem_write    <= 1'b0;
    end
    else
    begin
      mem_regwrite <= ex_regwrite;
      mem_memread  <= ex_memread;
      mem_memtoreg <= ex_memtoreg;
      mem_write    <= ex_memwrite;
    end
  end

  // Jumps carry the link address as their result
  always_ff @(posedge clk)
  begin
    mem_result <= (ex_jal | ex_jalr) ? link_pc : alu_y;
    mem_wdata  <= op_b;                    // Store data after forwarding
    mem_rd     <= ex_rd;
  end

endmodule

//--- rv32i_fetch.sv
// Program counter and IF/ID
`timescale 1ns/10ps
`include "rv32i_consts.svh"

module rv32i_fetch (
  input  logic                clk,
  input  logic                reset,
  input  logic [`RV_XLEN-1:0] inst,         // From instruction memory at pc
  input  logic                stall,
  input  logic                redirect,     // Taken branch or jump in execute
  input  logic [`RV_XLEN-1:0] redirect_pc,
  output logic [`RV_XLEN-1:0] pc,
  output logic [`RV_XLEN-1:0] id_inst,
  output logic [`RV_XLEN-1:0] id_pc
);

  // Redirect, then stall, then sequential
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      pc <= `RV_RESET_PC;
    else if (redirect)
      pc <= redirect_pc;
    else if (!stall)
      pc <= pc + `RV_XLEN'd4;
  end

  // Nop on reset so decode starts with controls off
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      id_inst <= `RV_NOP_INST;
    else if (redirect)
      id_inst <= `RV_NOP_INST;  // Squash wrong-path fetch
    else if (!stall)
      id_inst <= inst;
  end

  always_ff @(posedge clk)
  begin
    if (redirect || !stall)
      id_pc <= pc;
  end

endmodule

//--- rv32i_hazard_unit.sv
// Load-use stall and forward select
`timescale 1ns/10ps
`include "rv32i_consts.svh"

module rv32i_hazard_unit (
  input  logic [`RV_REG_ADDR_W-1:0] id_rs1,
  input  logic [`RV_REG_ADDR_W-1:0] id_rs2,
  input  logic [`RV_REG_ADDR_W-1:0] ex_rs1,
  input  logic [`RV_REG_ADDR_W-1:0] ex_rs2,
  input  logic [`RV_REG_ADDR_W-1:0] ex_rd,
  input  logic                      ex_memread,
  input  logic [`RV_REG_ADDR_W-1:0] mem_rd,
  input  logic                      mem_regwrite,
  input  logic                      mem_memread,   // Result there is an address
  input  logic [`RV_REG_ADDR_W-1:0] wb_rd,
  input  logic                      wb_we,
  output logic                      stall,
  output rv32i_pkg::fwd_sel_e       fwd_a,
  output rv32i_pkg::fwd_sel_e       fwd_b
);
  import rv32i_pkg::*;

  // Youngest producer wins, x0 never forwards
  function automatic fwd_sel_e src_fwd(input logic [`RV_REG_ADDR_W-1:0] src);
    if (mem_regwrite && !mem_memread && mem_rd != '0 && mem_rd == src)
      return FWD_MEM;
    else if (wb_we && wb_rd != '0 && wb_rd == src)
      return FWD_WB;
    else
      return FWD_NONE;
  endfunction

  // Load in execute feeding decode, hold one cycle
  assign stall = ex_memread && (ex_rd != '0) &&
                 ((ex_rd == id_rs1) || (ex_rd == id_rs2));

  always_comb
  begin
    fwd_a = src_fwd(ex_rs1);
    fwd_b = src_fwd(ex_rs2);
  end

endmodule

//--- rv32i_pkg.sv
// RV32I core types
package rv32i_pkg;

  // Major opcodes in inst[6:0]
  typedef enum logic [6:0] {
    OP_R       = 7'b0110011,  // add sub and or
    OP_I_ARITH = 7'b0010011,  // addi xori ori andi slli
    OP_LOAD    = 7'b0000011,  // lw
    OP_JALR    = 7'b1100111,
    OP_STORE   = 7'b0100011,  // sw
    OP_BRANCH  = 7'b1100011,  // beq bne blt bge bltu bgeu
    OP_LUI     = 7'b0110111,
    OP_JAL     = 7'b1101111
  } opcode_e;

  // ALU operations, bit 4 marks the subtract path
  typedef enum logic [4:0] {
    ALU_ADD = 5'b00000,
    ALU_AND = 5'b00001,
    ALU_OR  = 5'b00010,
    ALU_XOR = 5'b00011,
    ALU_SLL = 5'b00100,
    ALU_SUB = 5'b10000
  } alu_op_e;

  // Execute operand source
  typedef enum logic [1:0] {
    FWD_NONE = 2'b00,  // Value read in decode
    FWD_MEM  = 2'b01,  // EX/MEM result
    FWD_WB   = 2'b10   // Writeback data
  } fwd_sel_e;

endpackage

//--- rv32i_regfile.sv
// Integer register file
`timescale 1ns/10ps
`include "rv32i_consts.svh"

module rv32i_regfile (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [`RV_REG_ADDR_W-1:0] rs1,
  input  logic [`RV_REG_ADDR_W-1:0] rs2,
  input  logic [`RV_REG_ADDR_W-1:0] rd,       // Write index from writeback
  input  logic                      we,
  input  logic [`RV_XLEN-1:0]       rd_data,
  output logic [`RV_XLEN-1:0]       rs1_data,
  output logic [`RV_XLEN-1:0]       rs2_data
);

  logic [`RV_XLEN-1:0] regs [0:`RV_NUM_REGS-1];

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < `RV_NUM_REGS; i++)
        regs[i] <= '0;
    end
    else if (we && rd != '0)  // x0 never written
      regs[rd] <= rd_data;
  end

  // Write-through so decode sees the value retiring this cycle
  assign rs1_data = (rs1 == '0) ? '0 :
                    (we && rs1 == rd) ? rd_data : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 :
                    (we && rs2 == rd) ? rd_data : regs[rs2];

endmodule

//--- rv32i_writeback.sv
// MEM/WB register and result select
`timescale 1ns/10ps
`include "rv32i_consts.svh"

module rv32i_writeback (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [`RV_XLEN-1:0]       mem_result,
  input  logic [`RV_XLEN-1:0]       mem_rdata,     // Load data from the port
  input  logic [`RV_REG_ADDR_W-1:0] mem_rd,
  input  logic                      mem_regwrite,
  input  logic                      mem_memtoreg,
  output logic                      wb_we,
  output logic [`RV_REG_ADDR_W-1:0] wb_rd,
  output logic [`RV_XLEN-1:0]       wb_data
);

  logic                wb_memtoreg;
  logic [`RV_XLEN-1:0] wb_result;
  logic [`RV_XLEN-1:0] wb_rdata;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      wb_we       <= 1'b0;
      wb_memtoreg <= 1'b0;
    end
    else
    begin
      wb_we       <= mem_regwrite;
      wb_memtoreg <= mem_memtoreg;
    end
  end

  always_ff @(posedge clk)
  begin
    wb_rd     <= mem_rd;
    wb_result <= mem_result;
    wb_rdata  <= mem_rdata;
  end

  assign wb_data = wb_memtoreg ? wb_rdata : wb_result;  // Loads take memory data

endmodule

//--- tb_rv32i_cpu.sv
// RV32I core testbench
`timescale 1ns/10ps
`include "rv32i_consts.svh"

module tb_rv32i_cpu;
  import rv32i_pkg::*;

  localparam int          TIMEOUT_CYCLES = 20000;         // Program needs well under 1000
  localparam int          MODEL_STEPS    = 10000;
  localparam logic [31:0] SELF_JAL       = 32'h0000_006f; // jal x0, 0 parks the core

  logic                clk;
  logic                reset;
  logic [`RV_XLEN-1:0] inst, pc, mem_rdata, mem_addr, mem_wdata;
  logic                mem_write;

  logic [`RV_XLEN-1:0] imem [0:511];  // 2 KB program
  logic [`RV_XLEN-1:0] dmem [0:511];  // 2 KB data, loads below 0x400, stores above
  logic [`RV_XLEN-1:0] exp_addr [$];  // Store trace from the model
  logic [`RV_XLEN-1:0] exp_data [$];
  integer              seed;
  int                  errors, seen, n_exp, ip, store_off, wait_cycles;

  rv32i_cpu uut (
    .clk       (clk),
    .reset     (reset),
    .inst      (inst),
    .pc        (pc),
    .mem_rdata (mem_rdata),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_write (mem_write)
  );

  // Both memories answer in the same cycle
  assign inst      = imem[pc[10:2]];
  assign mem_rdata = dmem[mem_addr[10:2]];

  always @(posedge clk)
  begin
    if (mem_write)
      dmem[mem_addr[10:2]] <= mem_wdata;
  end

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Start-up data contents, different for every word
  function automatic logic [31:0] fill_word(int idx);
    return {idx[15:0] ^ 16'h3c5a, ~idx[15:0]};
  endfunction

  // Instruction formats
  function automatic logic [31:0] r_type(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_R};
  endfunction

  function automatic logic [31:0] i_type(logic [31:0] imm, int rs1, int f3, int rd,
                                         opcode_e op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] s_type(logic [31:0] imm, int rs2, int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OP_STORE};  // sw only
  endfunction

  function automatic logic [31:0] b_type(logic [31:0] imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic logic [31:0] j_type(logic [31:0] imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
  endfunction

  function automatic logic [31:0] u_type(logic [31:0] val, int rd);
    return {val[31:12], rd[4:0], OP_LUI};
  endfunction

  task automatic emit(logic [31:0] word);
    imem[ip[8:0]] = word;
    ip++;
  endtask

  // lui then addi, the addi reads the lui result at distance one
  task automatic put_const(int rd, logic [31:0] val);
    logic [31:0] upper;
    upper = val + 32'h800;  // Rounds for the sign-extended low part
    emit(u_type(upper, rd));
    emit(i_type(val, rd, 0, rd, OP_I_ARITH));
  endtask

  // Each store gets its own slot so a squashed one shows by address
  task automatic store_reg(int rs);
    emit(s_type(store_off, rs, 0));
    store_off += 4;
  endtask

  task automatic build_program();
    logic [31:0] va, vb, op1, op2;
    int          f3, at;
    for (int i = 0; i < 512; i++)
    begin
      imem[i[8:0]] = `RV_NOP_INST;
      dmem[i[8:0]] = fill_word(i);
    end
    ip        = 0;
    store_off = 'h400;
    for (int rnd = 0; rnd < 2; rnd++)
    begin
      for (int k = 0; k < 4; k++)  // add sub and or
      begin
        put_const(1, $random(seed));
        put_const(2, $random(seed));
        f3 = (k == 2) ? 7 : (k == 3) ? 6 : 0;
        emit(r_type((k == 1) ? 'h20 : 0, 2, 1, f3, 3));
        store_reg(3);
      end
      for (int k = 0; k < 5; k++)  // addi xori ori andi slli
      begin
        put_const(1, $random(seed));
        va = $random(seed);
        f3 = (k == 0) ? 0 : (k == 1) ? 4 : (k == 2) ? 6 : (k == 3) ? 7 : 1;
        if (k == 4)
          va = {27'd0, va[4:0]};  // Shift amount only
        emit(i_type(va, 1, f3, 3, OP_I_ARITH));
        store_reg(3);
      end
    end
    // Dependent chain
    put_const(1, $random(seed));
    put_const(2, $random(seed));
    emit(r_type(0, 2, 1, 0, 4));      // add x4, x1, x2
    emit(r_type('h20, 1, 4, 0, 5));   // sub x5, x4, x1
    emit(r_type(0, 4, 5, 6, 6));      // or x6, x5, x4, x4 two back
    store_reg(6);
    store_reg(5);
    // Load-use pairs
    va = $random(seed);
    emit(i_type(va & 32'h3fc, 0, 2, 7, OP_LOAD));   // lw x7 from the fill area
    emit(i_type(va >> 20, 7, 0, 8, OP_I_ARITH));    // addi x8, x7 right behind it
    store_reg(8);
    emit(i_type(32'h400, 0, 2, 9, OP_LOAD));        // First stored word
    emit(r_type(0, 7, 9, 0, 10));                   // add x10, x9, x7
    store_reg(10);
    emit(i_type(32'h3fc, 0, 2, 7, OP_LOAD));
    store_reg(7);                                   // Store data from the load
    // Six branches, each with (a,b), (b,a) and (a,a)
    for (int k = 0; k < 6; k++)
    begin
      va = $random(seed);
      vb = $random(seed);
      f3 = (k < 2) ? k : k + 2;
      for (int m = 0; m < 3; m++)
      begin
        op1 = (m == 1) ? vb : va;
        op2 = (m == 0) ? vb : va;
        put_const(1, op1);
        put_const(2, op2);
        emit(b_type(12, 2, 1, f3));  // Taken skips the next two
        store_reg(1);
        store_reg(2);
        store_reg(1);
      end
    end
    emit(j_type(12, 11));            // jal x11 over two stores
    store_reg(1);
    store_reg(2);
    store_reg(11);
    at = ip * 4;
    put_const(12, at + 15);
    emit(i_type(6, 12, 0, 13, OP_JALR));  // Lands on at + 20 once bit 0 is cleared
    store_reg(1);
    store_reg(2);
    store_reg(13);
    emit(i_type(123, 1, 0, 0, OP_I_ARITH));  // addi x0, x1, 123
    store_reg(0);
    emit(j_type(0, 0));
  endtask

  // Instruction-level RV32I model, builds the expected store trace
  function automatic int run_model();
    logic [31:0] r [0:31];
    logic [31:0] dm [0:511];
    logic [31:0] pc_m, nxt, ins, a, b, res, addr, imm_i, imm_s, imm_b, imm_j;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic        take, wr;
    int          steps;
    for (int i = 0; i < 32; i++)
      r[i[4:0]] = '0;
    for (int i = 0; i < 512; i++)
      dm[i[8:0]] = fill_word(i);
    pc_m  = `RV_RESET_PC;
    steps = 0;
    while (steps < MODEL_STEPS && imem[pc_m[10:2]] != SELF_JAL)
    begin
      ins   = imem[pc_m[10:2]];
      rd    = ins[11:7];
      f3    = ins[14:12];
      a     = r[ins[19:15]];
      b     = r[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      res   = '0;
      take  = 1'b0;
      wr    = 1'b1;
      nxt   = pc_m + 32'd4;
      case (opcode_e'(ins[6:0]))
        OP_R:
          case (f3)
            3'd7:    res = a & b;
            3'd6:    res = a | b;
            default: res = ins[30] ? a - b : a + b;
          endcase
        OP_I_ARITH:
          case (f3)
            3'd1:    res = a << ins[24:20];
            3'd4:    res = a ^ imm_i;
            3'd6:    res = a | imm_i;
            3'd7:    res = a & imm_i;
            default: res = a + imm_i;
          endcase
        OP_LUI:
          res = {ins[31:12], 12'd0};
        OP_LOAD:
        begin
          addr = a + imm_i;
          res  = dm[addr[10:2]];
        end
        OP_STORE:
        begin
          wr   = 1'b0;
          addr = a + imm_s;
          dm[addr[10:2]] = b;
          exp_addr.push_back(addr);
          exp_data.push_back(b);
        end
        OP_BRANCH:
        begin
          wr = 1'b0;
          case (f3)
            3'd0:    take = (a == b);
            3'd1:    take = (a != b);
            3'd4:    take = ($signed(a) < $signed(b));
            3'd5:    take = ($signed(a) >= $signed(b));
            3'd6:    take = (a < b);
            default: take = (a >= b);
          endcase
          if (take)
            nxt = pc_m + imm_b;
        end
        OP_JAL:
        begin
          res = nxt;  // Link
          nxt = pc_m + imm_j;
        end
        OP_JALR:
        begin
          res = nxt;
          nxt = (a + imm_i) & ~32'd1;
        end
        default: wr = 1'b0;
      endcase
      if (wr && rd != 5'd0)
        r[rd] = res;
      pc_m = nxt;
      steps++;
    end
    return exp_addr.size();
  endfunction

  task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("Mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Each store at the ports against the next one in the trace
  always @(posedge clk)
  begin
    if (!reset && mem_write)
    begin
      if (seen < n_exp)
      begin
        check_value($sformatf("store %0d address", seen), mem_addr, exp_addr[seen]);
        check_value($sformatf("store %0d data", seen), mem_wdata, exp_data[seen]);
      end
      else
      begin
        errors++;
        $display("Unexpected extra store at %0t ns to address %h", $time, mem_addr);
      end
      seen++;
    end
  end

  initial
  begin
    seed   = 32'h57a6_fcf8;
    reset  = 1'b1;
    errors = 0;
    seen   = 0;
    build_program();
    n_exp = run_model();
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    wait_cycles = 0;
    while (seen < n_exp && wait_cycles < TIMEOUT_CYCLES)  // Until the last store
    begin
      @(negedge clk);
      wait_cycles++;
    end
    if (seen < n_exp)
    begin
      errors++;
      $display("Timeout after %0d cycles with %0d of %0d stores seen", wait_cycles, seen,
               n_exp);
    end
    errors += uut.u_checker.fail_count;  // Assertion failures
    $display("Done: %0d of %0d stores seen, %0d errors", seen, n_exp, errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+.
rv32i_pkg.sv
rv32i_decoder.sv
rv32i_regfile.sv
rv32i_alu.sv
rv32i_hazard_unit.sv
rv32i_fetch.sv
rv32i_execute.sv
rv32i_writeback.sv
rv32i_cpu.sv
rv32i_checker.sv
tb_rv32i_cpu.sv
